// ==== rtl/cluster_config.svh ====
/*
 * Size and width macros of the compute cluster
 */
`ifndef CLUSTER_CONFIG_SVH
`define CLUSTER_CONFIG_SVH

// Warps per cluster, a power of two
`define CC_NUM_WARPS 8

// PC counts instruction words, not bytes
`define CC_PC_WIDTH 16

`define CC_INST_WIDTH 32

`define CC_TBLOCK_ID_BITS 8

// Set in a fetched word when the block ends there
`define CC_EXIT_BIT 31

`endif

// ==== rtl/cluster_pkg.sv ====
/*
 * Shared cluster types: warp index, PC, instruction, AXI read beats,
 * allocation request, done entry and warp state
 */
`include "cluster_config.svh"

package cluster_pkg;

    typedef logic [$clog2(`CC_NUM_WARPS)-1:0] warp_idx_t;
    typedef logic [`CC_PC_WIDTH-1:0]          pc_t;
    typedef logic [`CC_INST_WIDTH-1:0]        inst_t;
    typedef logic [`CC_TBLOCK_ID_BITS-1:0]    tblock_id_t;
    // Byte address of one instruction word
    typedef logic [`CC_PC_WIDTH+1:0]          imem_addr_t;

    typedef struct packed {
        pc_t        pc;
        tblock_id_t tblock_id;
    } alloc_req_t;

    // AXI id is the warp number
    typedef struct packed {
        warp_idx_t  id;
        imem_addr_t addr;
    } imem_ar_t;

    typedef struct packed {
        warp_idx_t  id;
        inst_t      data;
        logic [1:0] resp;
        logic       last;
    } imem_r_t;

    typedef struct packed {
        warp_idx_t  warp;
        tblock_id_t tblock_id;
    } done_entry_t;

    typedef enum logic [1:0] {FREE, WAIT_FETCH, WAIT_RESP, DONE} warp_state_e;

endpackage

// ==== rtl/stream_fifo.sv ====
/*
 * First-word-fall-through FIFO with a typed payload
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter int unsigned DEPTH = 8,
    parameter type data_t = logic [7:0]
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  push_i,
    input  data_t data_i,
    input  logic  pop_i,
    output data_t data_o,
    output logic  valid_o,
    output logic  full_o
);

    localparam int unsigned AW = $clog2(DEPTH);

    data_t       mem_q [DEPTH];
    // Extra top bit tells full from empty when the indices match
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;

    assign valid_o = wr_ptr_q != rd_ptr_q;
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign data_o  = mem_q[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q[AW-1:0]] <= data_i;
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> valid_o);

endmodule

// ==== rtl/warp_table.sv ====
/*
 * Per-warp state, PC and block id with allocation, fetch push,
 * response handling and release
 */
`timescale 1ns/1ps
`include "cluster_config.svh"

module warp_table import cluster_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        alloc_valid_i,
    input  alloc_req_t  alloc_i,
    output logic        free_o,
    output logic        fetch_push_o,
    output warp_idx_t   fetch_warp_o,
    input  warp_idx_t   pc_sel_i,
    output pc_t         pc_o,
    input  logic        resp_valid_i,
    input  imem_r_t     resp_i,
    output logic        done_push_o,
    output done_entry_t done_o,
    input  logic        release_i,
    input  warp_idx_t   release_warp_i
);

    warp_state_e state_q [`CC_NUM_WARPS];
    pc_t         pc_q [`CC_NUM_WARPS];
    tblock_id_t  tblock_q [`CC_NUM_WARPS];

    warp_idx_t alloc_idx;
    logic      alloc_fire;
    logic      resp_exit;
    // Warp allocated last cycle, it pushes ahead of any response
    logic      fresh_valid_q;
    warp_idx_t fresh_warp_q;

    // Lowest FREE warp and lowest WAIT_FETCH warp
    always_comb begin
        free_o       = 1'b0;
        alloc_idx    = '0;
        fetch_push_o = 1'b0;
        fetch_warp_o = '0;
        for (int i = `CC_NUM_WARPS - 1; i >= 0; i--) begin
            if (state_q[i] == FREE) begin
                free_o    = 1'b1;
                alloc_idx = warp_idx_t'(i);
            end
            if (state_q[i] == WAIT_FETCH) begin
                fetch_push_o = 1'b1;
                fetch_warp_o = warp_idx_t'(i);
            end
        end
        if (fresh_valid_q) fetch_warp_o = fresh_warp_q;
    end

    assign alloc_fire = alloc_valid_i && free_o;
    assign resp_exit  = resp_i.data[`CC_EXIT_BIT];
    assign pc_o       = pc_q[pc_sel_i];

    assign done_push_o      = resp_valid_i && resp_exit;
    assign done_o.warp      = resp_i.id;
    assign done_o.tblock_id = tblock_q[resp_i.id];

    // Each event touches a warp in a different state, so they never collide
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CC_NUM_WARPS; i++) begin
                state_q[i] <= FREE;
            end
            fresh_valid_q <= 1'b0;
            fresh_warp_q  <= '0;
        end else begin
            fresh_valid_q <= alloc_fire;
            fresh_warp_q  <= alloc_idx;
            if (alloc_fire) state_q[alloc_idx] <= WAIT_FETCH;
            if (fetch_push_o) state_q[fetch_warp_o] <= WAIT_RESP;
            if (resp_valid_i) state_q[resp_i.id] <= resp_exit ? DONE : WAIT_FETCH;
            if (release_i) state_q[release_warp_i] <= FREE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_fire) begin
            pc_q[alloc_idx]     <= alloc_i.pc;
            tblock_q[alloc_idx] <= alloc_i.tblock_id;
        end
        if (resp_valid_i && !resp_exit) begin
            pc_q[resp_i.id] <= pc_t'(pc_q[resp_i.id] + 1'b1);
        end
    end

    // Memory answers only ids that the fetch unit sent out
    a_resp_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_valid_i |-> state_q[resp_i.id] == WAIT_RESP);

    a_alloc_when_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_valid_i |-> free_o);

endmodule

// ==== rtl/fetch_unit.sv ====
/*
 * Instruction fetch: AR beats from queued warp requests, R beats
 * passed back to the warp table
 */
`timescale 1ns/1ps

module fetch_unit import cluster_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  warp_idx_t req_warp_i,
    input  pc_t       pc_i,
    output logic      req_pop_o,
    output imem_ar_t  ar_o,
    output logic      ar_valid_o,
    input  logic      ar_ready_i,
    input  imem_r_t   r_i,
    input  logic      r_valid_i,
    output logic      r_ready_o,
    output logic      resp_valid_o,
    output imem_r_t   resp_o
);

    logic r_ready_q;

    // PC is in words, AXI wants bytes
    assign ar_o.id    = req_warp_i;
    assign ar_o.addr  = {pc_i, 2'b00};
    assign ar_valid_o = req_valid_i;
    assign req_pop_o  = req_valid_i && ar_ready_i;

    // Every returning id has a warp waiting, so R is never stalled
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_ready_q <= 1'b0;
        end else begin
            r_ready_q <= 1'b1;
        end
    end

    assign r_ready_o    = r_ready_q;
    assign resp_valid_o = r_valid_i && r_ready_q;
    assign resp_o       = r_i;

    // Head warp and its PC must hold until the handshake
    a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

endmodule

// ==== rtl/compute_cluster.sv ====
/*
 * Cluster core: warp table, fetch queue, fetch unit and done queue
 */
`timescale 1ns/1ps
`include "cluster_config.svh"

module compute_cluster import cluster_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    output logic       warp_free_o,
    input  logic       allocate_warp_i,
    input  alloc_req_t allocate_i,
    input  logic       tblock_done_ready_i,
    output logic       tblock_done_o,
    output tblock_id_t tblock_done_id_o,
    output imem_ar_t   imem_ar_o,
    output logic       imem_ar_valid_o,
    input  logic       imem_ar_ready_i,
    input  imem_r_t    imem_r_i,
    input  logic       imem_r_valid_i,
    output logic       imem_r_ready_o
);

    logic        fetch_push;
    warp_idx_t   fetch_warp;
    logic        fetch_valid;
    warp_idx_t   fetch_head;
    logic        fetch_pop;
    pc_t         fetch_pc;
    logic        resp_valid;
    imem_r_t     resp;
    logic        done_push;
    done_entry_t done_entry;
    done_entry_t done_head;
    logic        done_pop;

    // Host taking the report frees the warp
    assign done_pop         = tblock_done_o && tblock_done_ready_i;
    assign tblock_done_id_o = done_head.tblock_id;

    warp_table wt0 (
        .clk_i          ( clk_i           ),
        .rst_n_i        ( rst_n_i         ),
        .alloc_valid_i  ( allocate_warp_i ),
        .alloc_i        ( allocate_i      ),
        .free_o         ( warp_free_o     ),
        .fetch_push_o   ( fetch_push      ),
        .fetch_warp_o   ( fetch_warp      ),
        .pc_sel_i       ( fetch_head      ),
        .pc_o           ( fetch_pc        ),
        .resp_valid_i   ( resp_valid      ),
        .resp_i         ( resp            ),
        .done_push_o    ( done_push       ),
        .done_o         ( done_entry      ),
        .release_i      ( done_pop        ),
        .release_warp_i ( done_head.warp  )
    );

    // One request per warp at most, so neither queue can fill past its depth
    stream_fifo #(.DEPTH(`CC_NUM_WARPS), .data_t(warp_idx_t)) fetch_q (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .push_i(fetch_push), .data_i(fetch_warp),
        .pop_i(fetch_pop), .data_o(fetch_head), .valid_o(fetch_valid), .full_o()
    );

    fetch_unit fu0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_valid_i(fetch_valid), .req_warp_i(fetch_head), .pc_i(fetch_pc),
        .req_pop_o(fetch_pop),
        .ar_o(imem_ar_o), .ar_valid_o(imem_ar_valid_o), .ar_ready_i(imem_ar_ready_i),
        .r_i(imem_r_i), .r_valid_i(imem_r_valid_i), .r_ready_o(imem_r_ready_o),
        .resp_valid_o(resp_valid), .resp_o(resp)
    );

    stream_fifo #(.DEPTH(`CC_NUM_WARPS), .data_t(done_entry_t)) done_q (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .push_i(done_push), .data_i(done_entry),
        .pop_i(done_pop), .data_o(done_head), .valid_o(tblock_done_o), .full_o()
    );

endmodule

// ==== rtl/compute_cluster_synth_wrapper.sv ====
/*
 * Top level: flat host and instruction-memory AXI read ports
 * around the compute cluster
 */
`timescale 1ns/1ps

module compute_cluster_synth_wrapper import cluster_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Thread block start
    output logic       warp_free_o,
    input  logic       allocate_warp_i,
    input  pc_t        allocate_pc_i,
    input  tblock_id_t allocate_tblock_id_i,

    // Thread block completion
    input  logic       tblock_done_ready_i,
    output logic       tblock_done_o,
    output tblock_id_t tblock_done_id_o,

    // Instruction memory, AXI read channels only
    output warp_idx_t  imem_axi_ar_id_o,
    output imem_addr_t imem_axi_ar_addr_o,
    output logic       imem_axi_ar_valid_o,
    input  logic       imem_axi_ar_ready_i,
    input  warp_idx_t  imem_axi_r_id_i,
    input  inst_t      imem_axi_r_data_i,
    input  logic [1:0] imem_axi_r_resp_i,
    input  logic       imem_axi_r_last_i,
    input  logic       imem_axi_r_valid_i,
    output logic       imem_axi_r_ready_o
);

    alloc_req_t alloc_req;
    imem_ar_t   imem_ar;
    imem_r_t    imem_r;

    assign alloc_req = '{pc: allocate_pc_i, tblock_id: allocate_tblock_id_i};
    assign imem_r    = '{id: imem_axi_r_id_i, data: imem_axi_r_data_i,
                         resp: imem_axi_r_resp_i, last: imem_axi_r_last_i};

    assign imem_axi_ar_id_o   = imem_ar.id;
    assign imem_axi_ar_addr_o = imem_ar.addr;

    compute_cluster cc0 (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .warp_free_o         ( warp_free_o         ),
        .allocate_warp_i     ( allocate_warp_i     ),
        .allocate_i          ( alloc_req           ),
        .tblock_done_ready_i ( tblock_done_ready_i ),
        .tblock_done_o       ( tblock_done_o       ),
        .tblock_done_id_o    ( tblock_done_id_o    ),
        .imem_ar_o           ( imem_ar             ),
        .imem_ar_valid_o     ( imem_axi_ar_valid_o ),
        .imem_ar_ready_i     ( imem_axi_ar_ready_i ),
        .imem_r_i            ( imem_r              ),
        .imem_r_valid_i      ( imem_axi_r_valid_i  ),
        .imem_r_ready_o      ( imem_axi_r_ready_o  )
    );

endmodule

// ==== verification/tb_compute_cluster.sv ====
/*
 * Compute cluster testbench: host driver, instruction memory model,
 * scoreboard assertions and watchdog
 */
`timescale 1ns/1ps
`include "cluster_config.svh"

module tb_compute_cluster import cluster_pkg::*; ();

    localparam int NW              = `CC_NUM_WARPS;
    localparam int NUM_BLOCKS      = 40;
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 200 + 1000;

    logic       clk, rst_n, allocate_warp, done_ready, ar_ready, r_valid, r_last;
    logic       warp_free, tblock_done, ar_valid, r_ready, hold_ready;
    logic [1:0] r_resp;
    pc_t        allocate_pc;
    tblock_id_t allocate_id, tblock_done_id;
    warp_idx_t  r_id, ar_id;
    inst_t      r_data;
    imem_addr_t ar_addr;
    int         seed = 32'h82ff;
    int         outstanding, next_id, n_reported;

    // Expected warp state, mirrored from the host side
    logic       w_busy [NW], w_out [NW], w_ended [NW];
    pc_t        w_pc [NW], w_start [NW];
    int         w_fetches [NW];
    tblock_id_t w_blk [NW];
    logic       alloc_seen [256], reported [256];
    warp_idx_t  blk_warp [256];
    // Memory requests in flight
    warp_idx_t  mem_id_q [$];
    imem_addr_t mem_addr_q [$];
    int         mem_delay_q [$];

    compute_cluster_synth_wrapper dut0 (
        .clk_i(clk), .rst_n_i(rst_n),
        .warp_free_o(warp_free), .allocate_warp_i(allocate_warp),
        .allocate_pc_i(allocate_pc), .allocate_tblock_id_i(allocate_id),
        .tblock_done_ready_i(done_ready), .tblock_done_o(tblock_done),
        .tblock_done_id_o(tblock_done_id),
        .imem_axi_ar_id_o(ar_id), .imem_axi_ar_addr_o(ar_addr),
        .imem_axi_ar_valid_o(ar_valid), .imem_axi_ar_ready_i(ar_ready),
        .imem_axi_r_id_i(r_id), .imem_axi_r_data_i(r_data), .imem_axi_r_resp_i(r_resp),
        .imem_axi_r_last_i(r_last), .imem_axi_r_valid_i(r_valid),
        .imem_axi_r_ready_o(r_ready)
    );

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // New block lands on the lowest idle warp
    task automatic mirror_alloc();
        int w;
        w = -1;
        for (int i = NW - 1; i >= 0; i--) begin
            if (!w_busy[i]) w = i;
        end
        w_busy[w]    = 1'b1;
        w_ended[w]   = 1'b0;
        w_pc[w]      = allocate_pc;
        w_start[w]   = allocate_pc;
        w_fetches[w] = 0;
        w_blk[w]     = allocate_id;
        alloc_seen[allocate_id] = 1'b1;
        blk_warp[allocate_id]   = warp_idx_t'(w);
        outstanding++;
    endtask

    task automatic check_ar_beat();
        imem_addr_t exp_addr;
        exp_addr = imem_addr_t'(w_pc[ar_id]) * imem_addr_t'(4);
        assert (w_busy[ar_id] && !w_ended[ar_id])
            else report_error("AR from a warp with no running block");
        assert (!w_out[ar_id]) else report_error("second AR outstanding on one id");
        assert (ar_addr == exp_addr)
            else report_error($sformatf("AR addr %h on id %0d, expected %h",
                                        ar_addr, ar_id, exp_addr));
        w_out[ar_id] = 1'b1;
        w_fetches[ar_id]++;
    endtask

    task automatic apply_r_beat();
        int exp_fetches;
        w_out[r_id] = 1'b0;
        if (r_data[`CC_EXIT_BIT]) begin
            exp_fetches = (3 - int'(w_start[r_id] % 4)) + 1;
            assert (w_fetches[r_id] == exp_fetches)
                else report_error($sformatf("block made %0d fetches, expected %0d",
                                            w_fetches[r_id], exp_fetches));
            w_ended[r_id] = 1'b1;
        end else begin
            w_pc[r_id] = w_pc[r_id] + 1'b1;
        end
    endtask

    task automatic retire_block();
        warp_idx_t w;
        w = blk_warp[tblock_done_id];
        assert (alloc_seen[tblock_done_id] && !reported[tblock_done_id])
            else report_error($sformatf("unexpected done id %0d", tblock_done_id));
        assert (w_busy[w] && w_ended[w] && w_blk[w] == tblock_done_id)
            else report_error("done reported before the block hit its exit word");
        reported[tblock_done_id] = 1'b1;
        w_busy[w] = 1'b0;
        outstanding--;
        n_reported++;
    endtask

    // Random AR ready, random latency, responses picked in any order
    task automatic serve_memory();
        int    start;
        int    idx;
        int    n;
        inst_t word;
        if (ar_valid && ar_ready) begin
            mem_id_q.push_back(ar_id);
            mem_addr_q.push_back(ar_addr);
            mem_delay_q.push_back(1 + int'($unsigned($random(seed)) % 6));
        end
        foreach (mem_delay_q[i]) begin
            if (mem_delay_q[i] > 0) mem_delay_q[i]--;
        end
        n = mem_delay_q.size();
        if (!r_valid || r_ready) begin
            r_valid <= 1'b0;
            idx = -1;
            start = (n > 0) ? int'($unsigned($random(seed)) % n) : 0;
            for (int k = 0; k < n; k++) begin
                if (idx < 0 && mem_delay_q[(start + k) % n] == 0) idx = (start + k) % n;
            end
            if (idx >= 0) begin
                // Block ends at each word index with remainder 3 modulo 4
                word = inst_t'($random(seed));
                word[`CC_EXIT_BIT] = ((mem_addr_q[idx] / 4) % 4) == 3;
                r_valid <= 1'b1;
                r_id    <= mem_id_q[idx];
                r_data  <= word;
                mem_id_q.delete(idx);
                mem_addr_q.delete(idx);
                mem_delay_q.delete(idx);
            end
        end
        ar_ready <= ($random(seed) & 3) != 0;
    endtask

    task automatic drive_host();
        if (outstanding < NW && next_id < NUM_BLOCKS) begin
            allocate_warp <= 1'b1;
            allocate_pc   <= pc_t'($random(seed));
            allocate_id   <= tblock_id_t'(next_id);
            next_id++;
        end else begin
            allocate_warp <= 1'b0;
        end
        done_ready <= hold_ready ? 1'b0 : 1'($random(seed));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            assert (warp_free == (outstanding < NW))
                else report_error($sformatf("warp_free_o %b with %0d blocks busy",
                                            warp_free, outstanding));
            if (allocate_warp && warp_free) mirror_alloc();
            if (ar_valid && ar_ready) check_ar_beat();
            if (r_valid && r_ready) apply_r_beat();
            if (tblock_done && done_ready) retire_block();
            serve_memory();
            drive_host();
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_id) && $stable(ar_addr))
        else report_error("AR id or address changed while waiting for ready");

    done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tblock_done && !done_ready |=> tblock_done && $stable(tblock_done_id))
        else report_error("done report changed while the host held ready low");

    initial begin
        rst_n = 1'b0;
        allocate_warp = 1'b0;
        allocate_pc = '0;
        allocate_id = '0;
        done_ready = 1'b0;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_id = '0;
        r_data = '0;
        r_resp = 2'b00;
        r_last = 1'b1;
        hold_ready = 1'b0;
        outstanding = 0;
        next_id = 0;
        n_reported = 0;
        for (int i = 0; i < NW; i++) begin
            w_busy[i] = 1'b0;
            w_out[i] = 1'b0;
            w_ended[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            alloc_seen[i] = 1'b0;
            reported[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!ar_valid && !tblock_done && warp_free)
            else report_error("outputs wrong right after reset");
        while (next_id < 16) @(negedge clk);
        // Host stops taking reports until every warp is busy
        @(posedge clk);
        hold_ready <= 1'b1;
        repeat (30) @(posedge clk);
        while (warp_free) @(negedge clk);
        @(posedge clk);
        hold_ready <= 1'b0;
        while (n_reported < NUM_BLOCKS) @(negedge clk);
        // With every block reported the cluster must be idle
        if (!tblock_done && !ar_valid && warp_free) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_error("cluster still busy after every block was reported");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: blocks still unfinished after %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/cluster_pkg.sv
rtl/stream_fifo.sv
rtl/warp_table.sv
rtl/fetch_unit.sv
rtl/compute_cluster.sv
rtl/compute_cluster_synth_wrapper.sv
verification/tb_compute_cluster.sv

// ==== run.sh ====
#!/bin/sh
# Build the compute cluster testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_compute_cluster \
    -Mdir obj_dir -f project.f || { echo "Verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vtb_compute_cluster 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "Result: PASSED" && exit 0 || exit 1
